// ==== pipe16_settings.svh ====
//////////////////////////////////////////////////
// pipe16 settings
// sizes and reset values shared by the core.
//////////////////////////////////////////////////

`ifndef PIPE16_SETTINGS_SVH
`define PIPE16_SETTINGS_SVH

// instruction memory depth in 16-bit words.
`define PIPE16_IMEM_DEPTH 64

// architectural register count.
`define PIPE16_NUM_REGS 8

// PC after reset and while run is low.
`define PIPE16_RESET_PC 16'h0000

`endif

// ==== pipe16Pkg.sv ====
//////////////////////////////////////////////////
// pipe16 package
// opcode and funct encodings, the two views of an
// instruction word and the records between stages.
//////////////////////////////////////////////////

package pipe16Pkg;

   // major opcode in bits 15:12, any other code is a no-op.
   typedef enum logic [3:0] {
      OP_ALU  = 4'h1,
      OP_ADDI = 4'h2,
      OP_ANDI = 4'h3,
      OP_BEQZ = 4'h4,
      OP_BNEZ = 4'h5,
      OP_HALT = 4'hf
   } opcodeT;

   // alu function for OP_ALU.
   typedef enum logic [2:0] {
      ADD = 3'd0,
      SUB = 3'd1,
      AND = 3'd2,
      OR  = 3'd3,
      XOR = 3'd4,
      SLL = 3'd5,
      SRL = 3'd6,
      SLT = 3'd7
   } functT;

   typedef struct packed {
      opcodeT     opcode;
      logic [2:0] rd;
      logic [2:0] rs;
      logic [2:0] rt;
      functT      funct;
   } rFmtT;

   typedef struct packed {
      opcodeT            opcode;
      logic [2:0]        rd;
      logic [2:0]        rs;
      logic signed [5:0] imm;
   } iFmtT;

   // one 16-bit word, read as register or immediate format.
   typedef union packed {
      rFmtT rFmt;
      iFmtT iFmt;
   } instrWordT;

   typedef struct packed {
      logic        en;
      logic [5:0]  addr;
      logic [15:0] data;
   } imemWrT;

   typedef struct packed {
      logic        valid;
      logic [15:0] pc;
      instrWordT   instr;
   } fetchOutT;

   typedef struct packed {
      logic        valid;
      logic [15:0] pc;
      opcodeT      op;
      functT       funct;
      logic [2:0]  rd;
      logic        wrEn;
      logic [15:0] opA;
      logic [15:0] opB;
      logic [15:0] imm;
   } decodeOutT;

   // also the retire report.
   typedef struct packed {
      logic        valid;
      logic [15:0] pc;
      logic        wrEn;
      logic [2:0]  rd;
      logic [15:0] data;
      logic        halt;
   } resultT;

   typedef struct packed {
      logic        take;
      logic [15:0] target;
   } redirectT;

endpackage

// ==== fetchStage.sv ====
//////////////////////////////////////////////////
// pipe16 fetch stage
// PC, instruction memory with load port, and the
// fetch-to-decode register.
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe16_settings.svh"

module fetchStage import pipe16Pkg::*; (
   input  logic     clk,
   input  logic     arstN,
   input  logic     run,
   input  imemWrT   imemWr,
   input  logic     stall,
   input  redirectT redirect,
   input  logic     halted,
   output fetchOutT fetchOut
);

   localparam int IMEM_AW = $clog2(`PIPE16_IMEM_DEPTH);

   logic [15:0] imem [`PIPE16_IMEM_DEPTH];
   logic [15:0] pc;
   logic [15:0] pcNext;
   instrWordT   fetchWord;
   logic        issue;

   // load port, written before run goes high.
   always_ff @(posedge clk) begin
      if (imemWr.en) begin
         imem[imemWr.addr] <= imemWr.data;
      end
   end

   // combinational read from the current PC.
   assign fetchWord = imem[pc[IMEM_AW-1:0]];

   // no new word when idle, halted or squashed.
   assign issue = run && !halted && !redirect.take;

   always_comb begin
      if (!run) begin
         pcNext = `PIPE16_RESET_PC;
      end else if (halted) begin
         pcNext = pc;
      end else if (redirect.take) begin
         pcNext = redirect.target;
      end else if (stall) begin
         pcNext = pc;
      end else begin
         pcNext = pc + 16'd1;
      end
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         pc <= `PIPE16_RESET_PC;
      end else begin
         pc <= pcNext;
      end
   end

   // fetch-to-decode register, frozen during a stall.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         fetchOut <= '0;
      end else if (!issue) begin
         fetchOut.valid <= 1'b0;
      end else if (!stall) begin
         fetchOut.valid <= 1'b1;
         fetchOut.pc    <= pc;
         fetchOut.instr <= fetchWord;
      end
   end

endmodule

// ==== decodeStage.sv ====
//////////////////////////////////////////////////
// pipe16 decode stage
// register file, field decode, hazard stall and
// the decode-to-execute register.
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe16_settings.svh"

module decodeStage import pipe16Pkg::*; (
   input  logic      clk,
   input  logic      arstN,
   input  fetchOutT  fetchOut,
   input  redirectT  redirect,
   input  resultT    wb,
   output logic      stall,
   output decodeOutT decodeOut
);

   logic [15:0] regs [`PIPE16_NUM_REGS];
   instrWordT   iw;
   opcodeT      op;
   logic        isR;
   logic        isImm;
   logic        isBranch;
   logic [2:0]  rd;
   logic [2:0]  rs;
   logic [2:0]  rt;
   logic [15:0] immExt;
   logic [15:0] rsVal;
   logic [15:0] rtVal;
   logic        exWrites;
   logic        rsHit;
   logic        rtHit;
   decodeOutT   decodeNext;

   // architectural registers clear to zero.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         for (int i = 0; i < `PIPE16_NUM_REGS; i++) begin
            regs[i] <= 16'd0;
         end
      end else if (wb.valid && wb.wrEn) begin
         regs[wb.rd] <= wb.data;
      end
   end

   assign iw = fetchOut.instr;
   assign op = iw.rFmt.opcode;

   always_comb begin
      isR      = (op == OP_ALU);
      isImm    = (op == OP_ADDI) || (op == OP_ANDI);
      isBranch = (op == OP_BEQZ) || (op == OP_BNEZ);
      // rd and rs sit at the same bits in both formats.
      rd     = iw.rFmt.rd;
      rs     = iw.rFmt.rs;
      rt     = iw.rFmt.rt;
      immExt = {{10{iw.iFmt.imm[5]}}, iw.iFmt.imm};
   end

   // reads see a write-back made in the same cycle.
   always_comb begin
      rsVal = regs[rs];
      rtVal = regs[rt];
      if (wb.valid && wb.wrEn && (wb.rd == rs)) begin
         rsVal = wb.data;
      end
      if (wb.valid && wb.wrEn && (wb.rd == rt)) begin
         rtVal = wb.data;
      end
   end

   // raw hazard against the instruction in execute.
   assign exWrites = decodeOut.valid && decodeOut.wrEn;
   assign rsHit    = (isR || isImm || isBranch) && (rs == decodeOut.rd);
   assign rtHit    = isR && (rt == decodeOut.rd);
   assign stall    = fetchOut.valid && exWrites && (rsHit || rtHit);

   always_comb begin
      // bubble on stall or redirect.
      decodeNext.valid = fetchOut.valid && !stall && !redirect.take;
      decodeNext.pc    = fetchOut.pc;
      decodeNext.op    = op;
      decodeNext.funct = iw.rFmt.funct;
      decodeNext.rd    = rd;
      decodeNext.wrEn  = isR || isImm;
      decodeNext.opA   = rsVal;
      decodeNext.opB   = rtVal;
      decodeNext.imm   = immExt;
   end

   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         decodeOut <= '0;
      end else begin
         decodeOut <= decodeNext;
      end
   end

endmodule

// ==== execStage.sv ====
//////////////////////////////////////////////////
// pipe16 execute stage
// ALU, branch resolution and the redirect pulse.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module execStage import pipe16Pkg::*; (
   input  logic      clk,
   input  logic      arstN,
   input  decodeOutT decodeOut,
   output redirectT  redirect,
   output resultT    exOut
);

   logic [3:0]  shamt;
   logic [15:0] functOut;
   logic [15:0] aluOut;
   logic        isZero;
   resultT      exNext;

   assign shamt = decodeOut.opB[3:0];

   always_comb begin
      functOut = 16'd0;
      case (decodeOut.funct)
         ADD: functOut = decodeOut.opA + decodeOut.opB;
         SUB: functOut = decodeOut.opA - decodeOut.opB;
         AND: functOut = decodeOut.opA & decodeOut.opB;
         OR:  functOut = decodeOut.opA | decodeOut.opB;
         XOR: functOut = decodeOut.opA ^ decodeOut.opB;
         SLL: functOut = decodeOut.opA << shamt;
         SRL: functOut = decodeOut.opA >> shamt;
         SLT: functOut = {15'd0, $signed(decodeOut.opA) < $signed(decodeOut.opB)};
      endcase
   end

   always_comb begin
      case (decodeOut.op)
         OP_ALU:  aluOut = functOut;
         OP_ADDI: aluOut = decodeOut.opA + decodeOut.imm;
         OP_ANDI: aluOut = decodeOut.opA & decodeOut.imm;
         default: aluOut = 16'd0;
      endcase
   end

   // branch target is pc + 1 + imm, in words.
   assign isZero = (decodeOut.opA == 16'd0);
   assign redirect.take = decodeOut.valid &&
                          (((decodeOut.op == OP_BEQZ) && isZero) ||
                           ((decodeOut.op == OP_BNEZ) && !isZero));
   assign redirect.target = decodeOut.pc + 16'd1 + decodeOut.imm;

   always_comb begin
      exNext.valid = decodeOut.valid;
      exNext.pc    = decodeOut.pc;
      exNext.wrEn  = decodeOut.wrEn;
      exNext.rd    = decodeOut.rd;
      exNext.data  = aluOut;
      exNext.halt  = (decodeOut.op == OP_HALT);
   end

   // execute-to-result register.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exOut <= '0;
      end else begin
         exOut <= exNext;
      end
   end

endmodule

// ==== resultStage.sv ====
//////////////////////////////////////////////////
// pipe16 result stage
// write-back, retire report and halted flag.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module resultStage import pipe16Pkg::*; (
   input  logic   clk,
   input  logic   arstN,
   input  resultT exOut,
   output resultT wb,
   output resultT retire,
   output logic   halted
);

   // nothing younger than a halt is allowed to retire.
   always_comb begin
      wb       = exOut;
      wb.valid = exOut.valid && !halted;
      wb.wrEn  = exOut.valid && exOut.wrEn && !halted;
   end

   assign retire = wb;

   // sticky until reset.
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         halted <= 1'b0;
      end else if (wb.valid && exOut.halt) begin
         halted <= 1'b1;
      end
   end

endmodule

// ==== pipe16Top.sv ====
//////////////////////////////////////////////////
// pipe16 top
// four-stage 16-bit core, fetch to result.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe16Top import pipe16Pkg::*; (
   input  logic   clk,
   input  logic   arstN,
   input  logic   run,
   input  imemWrT imemWr,
   output resultT retire,
   output logic   halted
);

   fetchOutT  fetchOut;
   decodeOutT decodeOut;
   resultT    exOut;
   resultT    wb;
   redirectT  redirect;
   logic      stall;

   fetchStage uFetch (
      .clk      (clk),
      .arstN    (arstN),
      .run      (run),
      .imemWr   (imemWr),
      .stall    (stall),
      .redirect (redirect),
      .halted   (halted),
      .fetchOut (fetchOut)
   );

   decodeStage uDecode (
      .clk       (clk),
      .arstN     (arstN),
      .fetchOut  (fetchOut),
      .redirect  (redirect),
      .wb        (wb),
      .stall     (stall),
      .decodeOut (decodeOut)
   );

   execStage uExec (
      .clk       (clk),
      .arstN     (arstN),
      .decodeOut (decodeOut),
      .redirect  (redirect),
      .exOut     (exOut)
   );

   resultStage uResult (
      .clk    (clk),
      .arstN  (arstN),
      .exOut  (exOut),
      .wb     (wb),
      .retire (retire),
      .halted (halted)
   );

endmodule

// ==== pipe16_checker.sv ====
//////////////////////////////////////////////////
// pipe16 checker
// protocol assertions on retire, halted and the
// redirect pulse, bound into the core top.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe16Checker import pipe16Pkg::*; (
   input logic     clk,
   input logic     arstN,
   input resultT   retire,
   input logic     halted,
   input redirectT redirect
);

   // retire stays quiet while reset is held.
   noRetireInReset: assert property (
      @(posedge clk) !arstN |-> !retire.valid
   ) else $error("retire pulsed while reset was active");

   // halted only clears through reset.
   haltedSticky: assert property (
      @(posedge clk) disable iff (!arstN) halted |=> halted
   ) else $error("halted fell without a reset");

   quietAfterHalt: assert property (
      @(posedge clk) disable iff (!arstN) halted |-> !retire.valid
   ) else $error("an instruction retired after halted was set");

   // a taken branch redirects for exactly one cycle.
   redirectPulse: assert property (
      @(posedge clk) disable iff (!arstN) redirect.take |=> !redirect.take
   ) else $error("redirect.take held for more than one cycle");

endmodule

bind pipe16Top pipe16Checker uChecker (
   .clk      (clk),
   .arstN    (arstN),
   .retire   (retire),
   .halted   (halted),
   .redirect (redirect)
);

// ==== pipe16ClkGen.sv ====
//////////////////////////////////////////////////
// pipe16 clock and reset
// 100 ns clock, reset held low for 4 cycles.
//////////////////////////////////////////////////

`timescale 1ns/1ps

module pipe16ClkGen (
   output logic clk,
   output logic arstN
);

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial begin
      arstN <= 1'b1;
      #10 arstN <= 1'b0;
      repeat (4) @(posedge clk);
      arstN <= 1'b1;
   end

endmodule

// ==== pipe16Tb.sv ====
//////////////////////////////////////////////////
// pipe16 testbench
// loads a program, runs it and checks every retire
// record against a trace built from the ISA rules.
//////////////////////////////////////////////////

`timescale 1ns/1ps
`include "pipe16_settings.svh"

module pipe16Tb import pipe16Pkg::*; ();

   logic        clk;
   logic        arstN;
   logic        run;
   imemWrT      imemWr;
   resultT      retire;
   logic        halted;
   logic [15:0] prog [$];
   resultT      trace [$];
   logic [15:0] model [`PIPE16_NUM_REGS];
   integer      seed = 32'hb8dc23b3;
   int          cycleCount = 0;
   int          timeoutLimit;
   int          traceIdx;

   pipe16ClkGen uClkGen (.clk(clk), .arstN(arstN));

   pipe16Top dut (
      .clk    (clk),
      .arstN  (arstN),
      .run    (run),
      .imemWr (imemWr),
      .retire (retire),
      .halted (halted)
   );

   task automatic endInFailure();
      $display("TEST RESULT: FAIL");
      $fatal(1, "stopped at the first error");
   endtask

   task automatic failPlain(input string reason);
      $display("%s", reason);
      endInFailure();
   endtask

   task automatic failValue(input string sigName, input logic [15:0] got,
                            input logic [15:0] exp);
      $display("Fail %s: got 0x%h, expected 0x%h", sigName, got, exp);
      endInFailure();
   endtask

   // rd and data only matter when the instruction writes.
   task automatic checkRetire(input resultT got, input resultT exp);
      if (got.pc !== exp.pc) begin
         failValue("retire.pc", got.pc, exp.pc);
      end else if (got.wrEn !== exp.wrEn) begin
         failValue("retire.wrEn", {15'd0, got.wrEn}, {15'd0, exp.wrEn});
      end else if (got.halt !== exp.halt) begin
         failValue("retire.halt", {15'd0, got.halt}, {15'd0, exp.halt});
      end else if (exp.wrEn && (got.rd !== exp.rd)) begin
         failValue("retire.rd", {13'd0, got.rd}, {13'd0, exp.rd});
      end else if (exp.wrEn && (got.data !== exp.data)) begin
         failValue("retire.data", got.data, exp.data);
      end
   endtask

   task automatic checkHalted(input logic got, input logic exp);
      if (got !== exp) begin
         failValue("halted", {15'd0, got}, {15'd0, exp});
      end
   endtask

   function automatic logic [15:0] aluRule(functT f, logic [15:0] a, logic [15:0] b);
      case (f)
         ADD:     return a + b;
         SUB:     return a - b;
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         SLL:     return a << b[3:0];
         SRL:     return a >> b[3:0];
         default: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
      endcase
   endfunction

   // expected record for the word about to be appended.
   task automatic pushTrace(logic wrEn, logic [2:0] rd, logic [15:0] data, logic halt);
      resultT r;
      r.valid = 1'b1;
      r.pc    = 16'(prog.size());
      r.wrEn  = wrEn;
      r.rd    = rd;
      r.data  = data;
      r.halt  = halt;
      trace.push_back(r);
   endtask

   task automatic emitR(functT f, logic [2:0] rd, logic [2:0] rs, logic [2:0] rt);
      instrWordT   w;
      logic [15:0] v;
      w.rFmt.opcode = OP_ALU;
      w.rFmt.rd     = rd;
      w.rFmt.rs     = rs;
      w.rFmt.rt     = rt;
      w.rFmt.funct  = f;
      v = aluRule(f, model[rs], model[rt]);
      pushTrace(1'b1, rd, v, 1'b0);
      prog.push_back(w);
      model[rd] = v;
   endtask

   task automatic emitImm(opcodeT op, logic [2:0] rd, logic [2:0] rs,
                          logic signed [5:0] imm);
      instrWordT   w;
      logic [15:0] ext;
      logic [15:0] v;
      w.iFmt.opcode = op;
      w.iFmt.rd     = rd;
      w.iFmt.rs     = rs;
      w.iFmt.imm    = imm;
      ext = 16'(imm);
      v = (op == OP_ADDI) ? (model[rs] + ext) : (model[rs] & ext);
      pushTrace(1'b1, rd, v, 1'b0);
      prog.push_back(w);
      model[rd] = v;
   endtask

   // words that must never retire.
   task automatic emitSkipped(int count);
      instrWordT w;
      w.iFmt.opcode = OP_ADDI;
      w.iFmt.rd     = 3'd1;
      w.iFmt.rs     = 3'd1;
      w.iFmt.imm    = 6'sd1;
      for (int k = 0; k < count; k++) begin
         prog.push_back(w);
      end
   endtask

   task automatic emitBranch(opcodeT op, logic [2:0] rs, logic signed [5:0] imm);
      instrWordT w;
      logic      taken;
      w.iFmt.opcode = op;
      w.iFmt.rd     = 3'd0;
      w.iFmt.rs     = rs;
      w.iFmt.imm    = imm;
      taken = (op == OP_BEQZ) ? (model[rs] == 16'd0) : (model[rs] != 16'd0);
      pushTrace(1'b0, 3'd0, 16'd0, 1'b0);
      prog.push_back(w);
      if (taken) begin
         emitSkipped(int'(imm));
      end
   endtask

   task automatic buildProgram();
      logic [31:0]       rnd;
      logic signed [5:0] immA;
      logic signed [5:0] immB;
      for (int i = 0; i < `PIPE16_NUM_REGS; i++) begin
         model[i] = 16'd0;
      end
      rnd  = $random(seed);
      immA = rnd[5:0];
      rnd  = $random(seed);
      immB = rnd[5:0];
      emitImm(OP_ADDI, 3'd1, 3'd0, immA);
      emitImm(OP_ADDI, 3'd2, 3'd0, immB);
      // all eight functs, the first one stalls on r2.
      for (int f = 0; f < 8; f++) begin
         emitR(functT'(3'(f)), 3'd3, 3'd1, 3'd2);
      end
      emitImm(OP_ADDI, 3'd4, 3'd1, -6'sd5);
      emitImm(OP_ANDI, 3'd5, 3'd4, -6'sd3);
      emitImm(OP_ANDI, 3'd6, 3'd2, 6'sd13);
      // r5 comes over the result-stage bypass.
      emitImm(OP_ADDI, 3'd7, 3'd5, -6'sd32);
      emitR(ADD, 3'd3, 3'd7, 3'd6);
      pushTrace(1'b0, 3'd0, 16'd0, 1'b0);
      prog.push_back(16'h0000);
      emitBranch(OP_BEQZ, 3'd0, 6'sd2);
      emitImm(OP_ADDI, 3'd6, 3'd0, -6'sd9);
      emitBranch(OP_BNEZ, 3'd6, 6'sd2);
      emitBranch(OP_BEQZ, 3'd6, 6'sd3);
      emitBranch(OP_BNEZ, 3'd0, 6'sd3);
      emitR(SUB, 3'd1, 3'd6, 3'd3);
      pushTrace(1'b0, 3'd0, 16'd0, 1'b1);
      prog.push_back({OP_HALT, 12'h000});
      emitSkipped(4);
   endtask

   // run-length guard, counted from the rise of run.
   always @(posedge clk) begin
      if (run) begin
         if (cycleCount >= timeoutLimit) begin
            failPlain("timeout: the program did not finish in time");
         end else begin
            cycleCount <= cycleCount + 1;
         end
      end
   end

   initial begin
      run    <= 1'b0;
      imemWr <= '0;
      buildProgram();
      timeoutLimit = 4 * prog.size() + 40;
      while (arstN !== 1'b1) begin
         @(posedge clk);
      end
      for (int i = 0; i < prog.size(); i++) begin
         @(posedge clk);
         imemWr.en   <= 1'b1;
         imemWr.addr <= 6'(i);
         imemWr.data <= prog[i];
      end
      @(posedge clk);
      imemWr.en <= 1'b0;
      run       <= 1'b1;
      traceIdx = 0;
      while (traceIdx < trace.size()) begin
         @(negedge clk);
         checkHalted(halted, 1'b0);
         if (retire.valid) begin
            checkRetire(retire, trace[traceIdx]);
            traceIdx++;
         end
      end
      @(negedge clk);
      checkHalted(halted, 1'b1);
      repeat (8) begin
         @(negedge clk);
         if (retire.valid) begin
            failPlain("an instruction retired after the halt");
         end else begin
            checkHalted(halted, 1'b1);
         end
      end
      $display("TEST RESULT: PASS");
      $finish;
   end

endmodule

// ==== pipe16.f ====
+incdir+.
pipe16Pkg.sv
fetchStage.sv
decodeStage.sv
execStage.sv
resultStage.sv
pipe16Top.sv
pipe16_checker.sv
pipe16ClkGen.sv
pipe16Tb.sv

// ==== Makefile ====
# Verilator build and run for the pipe16 core.

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = pipe16Tb
FLIST     = pipe16.f
PASS_MSG  = TEST RESULT: PASS

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
